//--- Makefile
# Verilator build and run for the bus interface testbench
# Any variable can be overridden, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_bus_interface
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from grep, so a missing pass line fails the target
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
source/bif_pkg.sv
source/bus_data_transceiver.sv
source/bif_cycle_timer.sv
source/bif_cycle_fsm.sv
source/bus_interface_top.sv
testbench/tb_bus_memory.sv
testbench/tb_bus_interface.sv

//--- source/bif_cycle_fsm.sv
//**********************************************************
// Bus cycle sequencer. Takes one local request, runs
// request, grant, address, data and acknowledge on the bus
//**********************************************************
`timescale 1ns/1ps

module bif_cycle_fsm (
  input  logic                            clkbd,        // Bus clock
  input  logic                            rst_n,        // Async reset, active low
  input  bif_pkg::bif_req_t               req,          // Local request
  input  logic                            req_valid,
  output logic                            req_ready,    // High only in IDLE
  output bif_pkg::bif_rsp_t               rsp,          // Local response
  output logic                            rsp_valid,    // High only in DONE
  input  logic                            rsp_ready,
  input  logic                            bgnt_n,       // Bus grant
  input  logic                            back_n,       // Target acknowledge
  output logic                            breq_n,       // Bus request
  output logic                            bas_n,        // Address strobe
  output logic                            bds_n,        // Data strobe
  output logic                            bwr_n,        // Low on write data phase
  output bif_pkg::xcvr_ctrl_t             xcvr_ctrl,    // Transceiver controls
  output logic [bif_pkg::BD_WIDTH-1:0]    local_data,   // Word for outbound register
  input  logic [bif_pkg::BD_WIDTH-1:0]    rdata,        // Inbound register
  output logic                            tmr_load,     // Restart timer
  output logic [bif_pkg::TIMER_WIDTH-1:0] tmr_value,    // Timer load value
  input  logic                            tmr_expired   // Timer reached zero
);

  bif_pkg::bif_state_e state_q;
  bif_pkg::bif_state_e state_d;
  bif_pkg::bif_req_t   req_q;      // Accepted request
  logic                err_q;      // Timeout seen in last cycle

  logic req_fire;                  // Request handshake
  logic rsp_fire;                  // Response handshake
  logic is_write;
  logic grant;                     // Grant seen while arbitrating
  logic addr_done;                 // Address hold elapsed
  logic ack;                       // Acknowledge in data phase
  logic timeout;                   // No acknowledge in time

  assign req_fire  = req_valid && req_ready;
  assign rsp_fire  = rsp_valid && rsp_ready;
  assign is_write  = (req_q.op == bif_pkg::BUS_WRITE);
  assign grant     = (state_q == bif_pkg::ARB) && !bgnt_n;
  assign addr_done = (state_q == bif_pkg::ADDR) && tmr_expired;
  assign ack       = (state_q == bif_pkg::DATA) && !back_n;
  assign timeout   = (state_q == bif_pkg::DATA) && back_n && tmr_expired;  // Ack wins a tie

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      bif_pkg::IDLE: if (req_fire) state_d = bif_pkg::ARB;
      bif_pkg::ARB:  if (grant) state_d = bif_pkg::ADDR;
      bif_pkg::ADDR: if (addr_done) state_d = bif_pkg::DATA;
      bif_pkg::DATA: if (ack || timeout) state_d = bif_pkg::DONE;
      bif_pkg::DONE: if (rsp_fire) state_d = bif_pkg::IDLE;
      default:       state_d = bif_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clkbd or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= bif_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload, only written on acceptance
  always_ff @(posedge clkbd) begin
    if (req_fire) begin
      req_q <= req;
    end
  end

  // Error flag, decided at the end of the data phase
  always_ff @(posedge clkbd or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (ack) begin
      err_q <= 1'b0;
    end else if (timeout) begin
      err_q <= 1'b1;
    end
  end

  // Local handshake outputs
  always_comb begin
    req_ready = (state_q == bif_pkg::IDLE);  // Blocks while a response waits
    rsp_valid = (state_q == bif_pkg::DONE);
    rsp.rdata = rdata;                       // Stable, transceiver idle in DONE
    rsp.err   = err_q;
  end

  // Bus strobes, all released in IDLE and DONE
  always_comb begin
    breq_n = !((state_q == bif_pkg::ARB) || (state_q == bif_pkg::ADDR) ||
               (state_q == bif_pkg::DATA));  // Held while we own the bus
    bas_n  = (state_q != bif_pkg::ADDR);
    bds_n  = (state_q != bif_pkg::DATA);
    bwr_n  = !((state_q == bif_pkg::DATA) && is_write);
  end

  // Transceiver controls
  always_comb begin
    xcvr_ctrl.cap_local = grant || (addr_done && is_write);  // Address, then wdata
    xcvr_ctrl.cap_bus   = ack && !is_write;                  // Read data on ack edge
    xcvr_ctrl.oe        = (state_q == bif_pkg::ADDR) ||
                          ((state_q == bif_pkg::DATA) && is_write);
    xcvr_ctrl.clr_in    = timeout || (ack && is_write);      // rdata zero
    // Address is loaded from ARB, write data from ADDR
    local_data = (state_q == bif_pkg::ARB) ? req_q.addr : req_q.wdata;
  end

  // Timer reload, one less than the phase length since expired
  // is seen during the last clock of the phase
  always_comb begin
    tmr_load = grant || addr_done;
    if (state_q == bif_pkg::ARB) begin
      tmr_value = bif_pkg::ADDR_HOLD_CYCLES[bif_pkg::TIMER_WIDTH-1:0] - 1'b1;
    end else begin
      tmr_value = bif_pkg::ACK_TIMEOUT[bif_pkg::TIMER_WIDTH-1:0] - 1'b1;
    end
  end

endmodule

//--- source/bif_cycle_timer.sv
//**********************************************************
// Loadable down-counter for the address hold time and the
// acknowledge timeout. Load N, expired rises N clocks later
//**********************************************************
`timescale 1ns/1ps

module bif_cycle_timer (
  input  logic                            clkbd,       // Bus clock
  input  logic                            rst_n,       // Async reset, active low
  input  logic                            load,        // Restart with load_value
  input  logic [bif_pkg::TIMER_WIDTH-1:0] load_value,  // Clocks until expired
  output logic                            expired      // Count reached zero
);

  logic [bif_pkg::TIMER_WIDTH-1:0] count_q;  // Remaining clocks
  logic                            armed_q;  // Counting since last load

  always_ff @(posedge clkbd or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      armed_q <= 1'b0;                   // Idle, no expiry after reset
    end else if (load) begin
      count_q <= load_value;             // Load wins over expiry
      armed_q <= 1'b1;
    end else if (armed_q) begin
      if (count_q == '0) begin
        armed_q <= 1'b0;                 // One expired clock, then idle
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Decoded straight from the count so the sequencer sees it
  // in the same clock the count hits zero
  assign expired = armed_q && (count_q == '0);

endmodule

//--- source/bif_pkg.sv
//**********************************************************
// Shared widths, cycle constants, structs and enums for the
// bus interface data path. Referenced by bif_pkg:: names
//**********************************************************
package bif_pkg;

  localparam int BD_WIDTH         = 24;  // Multiplexed address/data bus width
  localparam int ADDR_HOLD_CYCLES = 2;   // Clocks with bas_n low
  localparam int ACK_TIMEOUT      = 16;  // Data phase clocks before error
  localparam int TIMER_WIDTH      = 5;   // Must hold ACK_TIMEOUT

  // Bus cycle type
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

  // Bus cycle sequencer states
  typedef enum logic [2:0] {
    IDLE = 3'd0,  // Ready for a local request
    ARB  = 3'd1,  // breq_n low, waiting for bgnt_n
    ADDR = 3'd2,  // Address on bus, bas_n low
    DATA = 3'd3,  // bds_n low, waiting for back_n
    DONE = 3'd4   // Bus released, response offered
  } bif_state_e;

  // Local request, op in the top bit
  typedef struct packed {
    bus_op_e               op;     // Read or write
    logic [BD_WIDTH-1:0]   addr;   // Word address
    logic [BD_WIDTH-1:0]   wdata;  // Ignored on reads
  } bif_req_t;

  // Local response
  typedef struct packed {
    logic [BD_WIDTH-1:0]   rdata;  // Zero on writes and timeouts
    logic                  err;    // No acknowledge within ACK_TIMEOUT
  } bif_rsp_t;

  // Transceiver controls from the sequencer
  typedef struct packed {
    logic cap_local;  // Load outbound register from local side
    logic cap_bus;    // Load inbound register from bus
    logic oe;         // Drive outbound register onto bus
    logic clr_in;     // Zero inbound register
  } xcvr_ctrl_t;

endpackage

//--- source/bus_data_transceiver.sv
//**********************************************************
// Registered 24-bit transceiver between local data and the
// active-low wired-AND system bus, one register per direction
//**********************************************************
`timescale 1ns/1ps

module bus_data_transceiver (
  input  logic                         clkbd,       // Bus clock
  input  logic                         rst_n,       // Async reset, active low
  input  bif_pkg::xcvr_ctrl_t          ctrl,        // Capture and enable controls
  input  logic [bif_pkg::BD_WIDTH-1:0] local_data,  // Address or write data
  output logic [bif_pkg::BD_WIDTH-1:0] rdata,       // Inbound register, true polarity
  input  logic [bif_pkg::BD_WIDTH-1:0] bd_n_in,     // Sampled bus, active low
  output logic [bif_pkg::BD_WIDTH-1:0] bd_n_out     // Bus drive, all ones when idle
);

  // Outbound register keeps the inverted word, ready for the bus
  logic [bif_pkg::BD_WIDTH-1:0] out_n_q;
  // Inbound register keeps the word in true polarity
  logic [bif_pkg::BD_WIDTH-1:0] in_q;

  // Local to bus path
  always_ff @(posedge clkbd or negedge rst_n) begin
    if (!rst_n) begin
      out_n_q <= '1;                     // Inverted zero
    end else if (ctrl.cap_local) begin
      out_n_q <= ~local_data;            // Invert on the way in
    end
  end

  // Bus to local path
  always_ff @(posedge clkbd or negedge rst_n) begin
    if (!rst_n) begin
      in_q <= '0;
    end else if (ctrl.clr_in) begin
      in_q <= '0;                        // Timeout or write, no read data
    end else if (ctrl.cap_bus) begin
      in_q <= ~bd_n_in;                  // Undo bus inversion
    end
  end

  // A line we do not drive must float high on the wired-AND bus,
  // so the output is released to all ones rather than tri-stated
  assign bd_n_out = ctrl.oe ? out_n_q : '1;

  assign rdata = in_q;                   // Held stable until next capture

endmodule

//--- source/bus_interface_top.sv
//**********************************************************
// Bus interface data path top. Local valid/ready requests
// in, active-low multiplexed system bus cycles out
//**********************************************************
`timescale 1ns/1ps

module bus_interface_top (
  input  logic                         clkbd,      // Bus clock
  input  logic                         rst_n,      // Async reset, active low
  input  bif_pkg::bif_req_t            req,        // Local request
  input  logic                         req_valid,
  output logic                         req_ready,
  output bif_pkg::bif_rsp_t            rsp,        // Local response
  output logic                         rsp_valid,
  input  logic                         rsp_ready,
  output logic                         breq_n,     // Bus request
  input  logic                         bgnt_n,     // Bus grant
  output logic                         bas_n,      // Address strobe
  output logic                         bds_n,      // Data strobe
  output logic                         bwr_n,      // Write
  input  logic                         back_n,     // Acknowledge
  input  logic [bif_pkg::BD_WIDTH-1:0] bd_n_in,    // Sampled bus data
  output logic [bif_pkg::BD_WIDTH-1:0] bd_n_out    // Driven bus data, inverted
);

  bif_pkg::xcvr_ctrl_t             xcvr_ctrl;    // Sequencer to transceiver
  logic [bif_pkg::BD_WIDTH-1:0]    local_data;   // Address or write data
  logic [bif_pkg::BD_WIDTH-1:0]    rdata;        // Inbound register
  logic                            tmr_load;
  logic [bif_pkg::TIMER_WIDTH-1:0] tmr_value;
  logic                            tmr_expired;

  bif_cycle_fsm cycle_fsm_inst (
    .clkbd       (clkbd),
    .rst_n       (rst_n),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .rsp         (rsp),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .bgnt_n      (bgnt_n),
    .back_n      (back_n),
    .breq_n      (breq_n),
    .bas_n       (bas_n),
    .bds_n       (bds_n),
    .bwr_n       (bwr_n),
    .xcvr_ctrl   (xcvr_ctrl),
    .local_data  (local_data),
    .rdata       (rdata),
    .tmr_load    (tmr_load),
    .tmr_value   (tmr_value),
    .tmr_expired (tmr_expired)
  );

  // Shared by address hold and acknowledge timeout
  bif_cycle_timer cycle_timer_inst (
    .clkbd      (clkbd),
    .rst_n      (rst_n),
    .load       (tmr_load),
    .load_value (tmr_value),
    .expired    (tmr_expired)
  );

  bus_data_transceiver data_xcvr_inst (
    .clkbd      (clkbd),
    .rst_n      (rst_n),
    .ctrl       (xcvr_ctrl),
    .local_data (local_data),
    .rdata      (rdata),
    .bd_n_in    (bd_n_in),
    .bd_n_out   (bd_n_out)
  );

endmodule

//--- testbench/tb_bus_interface.sv
//**********************************************************
// Directed tests for the bus interface top against a bus
// memory model, with a scoreboard and a watchdog
//**********************************************************
`timescale 1ns/1ps

module tb_bus_interface;

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 400;  // Watchdog budget per test
  localparam int WAIT_LIMIT      = 100;  // Longest handshake wait in clocks

  logic                clkbd;
  logic                rst_n;
  bif_pkg::bif_req_t   req;
  logic                req_valid;
  logic                req_ready;
  bif_pkg::bif_rsp_t   rsp;
  logic                rsp_valid;
  logic                rsp_ready;
  logic                breq_n;
  logic                bgnt_n;
  logic                bas_n;
  logic                bds_n;
  logic                bwr_n;
  logic                back_n;
  logic [23:0]         bd_n_in;
  logic [23:0]         bd_n_out;
  int                  grant_delay;

  logic [23:0] expected_mem [0:255];  // Scoreboard copy of the target
  logic [31:0] rng_state;
  int          check_count = 0;
  int          error_count = 0;

  bus_interface_top bus_interface_top_inst (
    .clkbd(clkbd), .rst_n(rst_n),
    .req(req), .req_valid(req_valid), .req_ready(req_ready),
    .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
    .breq_n(breq_n), .bgnt_n(bgnt_n), .bas_n(bas_n), .bds_n(bds_n),
    .bwr_n(bwr_n), .back_n(back_n), .bd_n_in(bd_n_in), .bd_n_out(bd_n_out)
  );

  tb_bus_memory bus_memory_inst (
    .clkbd(clkbd), .rst_n(rst_n), .grant_delay(grant_delay),
    .breq_n(breq_n), .bas_n(bas_n), .bds_n(bds_n), .bwr_n(bwr_n),
    .bd_n_out(bd_n_out), .bgnt_n(bgnt_n), .back_n(back_n), .bd_n_in(bd_n_in)
  );

  initial begin
    clkbd = 1'b0;
    forever #5 clkbd = ~clkbd;          // 10 ns period
  end

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clkbd);
    $display("Watchdog expired, tests did not finish in %0d clocks",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("Testbench failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [23:0] got,
                             input logic [23:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_count++;
    assert (cond) else begin
      error_count++;
      $display("%s at %0t", what, $time);
    end
  endtask

  // Offers one request and returns 1 ns after the accepting edge
  task automatic issue_request(input bif_pkg::bus_op_e op, input logic [23:0] addr,
                               input logic [23:0] wdata);
    int waited;
    waited = 0;
    req.op    = op;
    req.addr  = addr;
    req.wdata = wdata;
    req_valid = 1'b1;
    while (!req_ready && waited < WAIT_LIMIT) begin
      @(posedge clkbd);
      #1;
      waited++;
    end
    check_true(req_ready, "Request was never accepted");
    @(posedge clkbd);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic collect_response(output bif_pkg::bif_rsp_t rsp_out);
    int waited;
    waited = 0;
    while (!rsp_valid && waited < WAIT_LIMIT) begin
      @(posedge clkbd);
      #1;
      waited++;
    end
    check_true(rsp_valid, "Response never arrived");
    rsp_out = rsp;                      // Held stable up to the handshake edge
    @(posedge clkbd);
    #1;
  endtask

  task automatic run_cycle(input bif_pkg::bus_op_e op, input logic [23:0] addr,
                           input logic [23:0] wdata, output bif_pkg::bif_rsp_t rsp_out);
    issue_request(op, addr, wdata);
    collect_response(rsp_out);
  endtask

  task automatic check_reset_state();
    check_flag("req_ready", req_ready, 1'b1);
    check_flag("rsp_valid", rsp_valid, 1'b0);
    check_flag("breq_n", breq_n, 1'b1);
    check_flag("bas_n", bas_n, 1'b1);
    check_flag("bds_n", bds_n, 1'b1);
    check_flag("bwr_n", bwr_n, 1'b1);
    check_value("bd_n_out", bd_n_out, 24'hFFFFFF);
  endtask

  task automatic test_write_read();
    logic [23:0]       data;
    bif_pkg::bif_rsp_t r;
    rng_state = xorshift32(rng_state);
    data      = rng_state[23:0];
    run_cycle(bif_pkg::BUS_WRITE, 24'h00003C, data, r);
    check_flag("rsp.err", r.err, 1'b0);
    check_value("rsp.rdata", r.rdata, 24'h000000);  // Writes return no data
    expected_mem[8'h3C] = data;
    run_cycle(bif_pkg::BUS_READ, 24'h00003C, 24'h000000, r);
    check_flag("rsp.err", r.err, 1'b0);
    check_value("rsp.rdata", r.rdata, data);
  endtask

  task automatic test_unwritten_read();
    bif_pkg::bif_rsp_t r;
    run_cycle(bif_pkg::BUS_READ, 24'h0000C7, 24'h000000, r);
    check_flag("rsp.err", r.err, 1'b0);
    check_value("rsp.rdata", r.rdata, 24'h0000C7 ^ 24'hA5A5A5);
  endtask

  task automatic test_out_of_range();
    bif_pkg::bif_rsp_t r;
    run_cycle(bif_pkg::BUS_WRITE, 24'h123456, 24'h0F0F0F, r);
    check_flag("rsp.err", r.err, 1'b1);
    check_value("rsp.rdata", r.rdata, 24'h000000);
    // Same low byte inside the range stays untouched
    run_cycle(bif_pkg::BUS_READ, 24'h000056, 24'h000000, r);
    check_flag("rsp.err", r.err, 1'b0);
    check_value("rsp.rdata", r.rdata, expected_mem[8'h56]);
    run_cycle(bif_pkg::BUS_READ, 24'h000100, 24'h000000, r);
    check_flag("rsp.err", r.err, 1'b1);
    check_value("rsp.rdata", r.rdata, 24'h000000);
  endtask

  // Bus strobes sampled mid cycle on the falling edge
  task automatic test_grant_delay();
    int                wait_cycles;
    int                addr_cycles;
    int                guard;
    bif_pkg::bif_rsp_t r;
    wait_cycles = 0;
    addr_cycles = 0;
    guard       = 0;
    grant_delay = 10;
    issue_request(bif_pkg::BUS_READ, 24'h00005A, 24'h000000);
    @(negedge clkbd);
    while (bgnt_n && guard < WAIT_LIMIT) begin
      check_flag("breq_n", breq_n, 1'b0);
      check_flag("bas_n", bas_n, 1'b1);     // No address before grant
      wait_cycles++;
      guard++;
      @(negedge clkbd);
    end
    check_true(wait_cycles == 10, "Grant came after the wrong number of clocks");
    while (bas_n && guard < WAIT_LIMIT) begin
      guard++;
      @(negedge clkbd);
    end
    while (!bas_n && guard < WAIT_LIMIT) begin
      check_value("bd_n_out", bd_n_out, ~24'h00005A);
      addr_cycles++;
      guard++;
      @(negedge clkbd);
    end
    check_true(addr_cycles == bif_pkg::ADDR_HOLD_CYCLES,
               "Address phase had the wrong length");
    check_flag("bds_n", bds_n, 1'b0);     // Data phase follows the address
    check_flag("bwr_n", bwr_n, 1'b1);     // Read cycle
    @(posedge clkbd);
    #1;
    collect_response(r);
    check_flag("rsp.err", r.err, 1'b0);
    check_value("rsp.rdata", r.rdata, expected_mem[8'h5A]);
    grant_delay = 0;                      // Bus is idle again here
  endtask

  task automatic test_backpressure();
    bif_pkg::bif_rsp_t held;
    int                waited;
    waited    = 0;
    rsp_ready = 1'b0;
    issue_request(bif_pkg::BUS_READ, 24'h000021, 24'h000000);
    while (!rsp_valid && waited < WAIT_LIMIT) begin
      @(posedge clkbd);
      #1;
      waited++;
    end
    check_true(rsp_valid, "Response never arrived under back-pressure");
    held = rsp;
    check_value("rsp.rdata", held.rdata, expected_mem[8'h21]);
    check_flag("rsp.err", held.err, 1'b0);
    // A second request must wait while the response is pending
    req.op    = bif_pkg::BUS_WRITE;
    req.addr  = 24'h000022;
    req.wdata = 24'h123456;
    req_valid = 1'b1;
    repeat (8) begin
      @(posedge clkbd);
      #1;
      check_flag("rsp_valid", rsp_valid, 1'b1);
      check_value("rsp.rdata", rsp.rdata, held.rdata);
      check_flag("rsp.err", rsp.err, held.err);
      check_flag("req_ready", req_ready, 1'b0);
    end
    req_valid = 1'b0;
    rsp_ready = 1'b1;
    @(posedge clkbd);
    #1;
    check_flag("rsp_valid", rsp_valid, 1'b0);
    check_flag("req_ready", req_ready, 1'b1);
  endtask

  task automatic test_random_traffic();
    logic              is_write;
    logic [23:0]       addr;
    logic [23:0]       data;
    bif_pkg::bif_rsp_t r;
    for (int i = 0; i < 40; i++) begin
      rng_state = xorshift32(rng_state);
      is_write  = rng_state[0];
      addr      = {16'h0000, rng_state[15:8]};
      rng_state = xorshift32(rng_state);
      data      = rng_state[23:0];
      if (is_write) begin
        run_cycle(bif_pkg::BUS_WRITE, addr, data, r);
        check_value("rsp.rdata", r.rdata, 24'h000000);
        expected_mem[addr[7:0]] = data;
      end else begin
        run_cycle(bif_pkg::BUS_READ, addr, 24'h000000, r);
        check_value("rsp.rdata", r.rdata, expected_mem[addr[7:0]]);
      end
      check_flag("rsp.err", r.err, 1'b0);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    req         = '0;
    req_valid   = 1'b0;
    rsp_ready   = 1'b1;
    grant_delay = 0;
    rng_state   = 32'd8461;
    for (int i = 0; i < 256; i++) begin
      expected_mem[i] = i[23:0] ^ 24'hA5A5A5;
    end
    repeat (3) @(posedge clkbd);
    #1;
    rst_n = 1'b1;
    check_reset_state();
    test_unwritten_read();
    test_write_read();
    test_out_of_range();
    test_grant_delay();
    test_backpressure();
    test_random_traffic();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- testbench/tb_bus_memory.sv
//**********************************************************
// Behavioral bus target with 256 words at 0x000000-0x0000FF.
// Grant after a set delay, acknowledge 2 clocks into data
//**********************************************************
`timescale 1ns/1ps

module tb_bus_memory (
  input  logic        clkbd,        // Bus clock
  input  logic        rst_n,        // Async reset, active low
  input  int          grant_delay,  // Clocks of breq_n before bgnt_n
  input  logic        breq_n,
  input  logic        bas_n,
  input  logic        bds_n,
  input  logic        bwr_n,
  input  logic [23:0] bd_n_out,     // Bus as driven by the DUT
  output logic        bgnt_n,
  output logic        back_n,
  output logic [23:0] bd_n_in       // Bus as seen by the DUT
);

  logic [23:0] mem [0:255];         // Word storage
  logic [23:0] cur_addr;            // Latched in the address phase
  int          gnt_wait;            // Clocks of request seen so far
  int          ack_wait;            // Clocks of data strobe seen so far

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = i[23:0] ^ 24'hA5A5A5;  // Fill from the whole address
    end
    bgnt_n   = 1'b1;
    back_n   = 1'b1;
    bd_n_in  = '1;                  // Undriven bus floats high
    cur_addr = '0;
    gnt_wait = 0;
    ack_wait = 0;
  end

  always @(posedge clkbd) begin
    if (!rst_n) begin
      bgnt_n   = 1'b1;
      back_n   = 1'b1;
      bd_n_in  = '1;
      gnt_wait = 0;
      ack_wait = 0;
    end else begin
      #1;                           // Respond just after the edge
      if (breq_n) begin
        bgnt_n   = 1'b1;            // Request dropped, take grant back
        gnt_wait = 0;
      end else if (gnt_wait >= grant_delay) begin
        bgnt_n = 1'b0;
      end else begin
        gnt_wait++;
      end
      if (!bas_n) begin
        cur_addr = ~bd_n_out;       // Address lines are active low
      end
      if (bds_n) begin
        back_n   = 1'b1;            // Release after the data phase
        bd_n_in  = '1;
        ack_wait = 0;
      end else begin
        ack_wait++;
        // Out of range addresses never see an acknowledge
        if (ack_wait == 2 && cur_addr[23:8] == 16'h0000) begin
          back_n = 1'b0;
          if (!bwr_n) begin
            mem[cur_addr[7:0]] = ~bd_n_out;
          end else begin
            bd_n_in = ~mem[cur_addr[7:0]];
          end
        end
      end
    end
  end

endmodule
